//--- hw/zpu_isa_pkg.sv
package zpu_isa_pkg;

    ////////////////////////////////////////////////////////////////////
    // opcode bytes
    ////////////////////////////////////////////////////////////////////

    localparam logic [7:0] op_add_c       = 8'h05;
    localparam logic [7:0] op_and_c       = 8'h06;
    localparam logic [7:0] op_or_c        = 8'h07;
    localparam logic [7:0] op_not_c       = 8'h09;
    localparam logic [7:0] op_flip_c      = 8'h0A;
    localparam logic [7:0] op_nop_c       = 8'h0B;
    localparam logic [7:0] op_lessthan_c  = 8'h24;
    localparam logic [7:0] op_ulessthan_c = 8'h26;
    localparam logic [7:0] op_mult_c      = 8'h29;
    localparam logic [7:0] op_eq_c        = 8'h2E;
    localparam logic [7:0] op_sub_c       = 8'h31;

    ////////////////////////////////////////////////////////////////////
    // execute operations
    ////////////////////////////////////////////////////////////////////

    // im0 starts a constant, imn extends the one on tos
    typedef enum logic [3:0] {
        exe_nop,
        exe_im0,
        exe_imn,
        exe_add,
        exe_and,
        exe_or,
        exe_not,
        exe_flip,
        exe_sub,
        exe_eq,
        exe_lessthan,
        exe_ulessthan,
        exe_mul
    } exec_op_e;

endpackage

//--- hw/zpu_data_pkg.sv
package zpu_data_pkg;

    // one stack entry
    typedef logic [31:0] word_t;

    // payload bits carried by an im byte
    localparam int IMM_WIDTH = 7;

    typedef logic [IMM_WIDTH-1:0] imm_t;

    // defaults for the top level
    localparam int DEF_FIFO_DEPTH  = 4;
    localparam int DEF_STACK_DEPTH = 8;

endpackage

//--- hw/op_decoder.sv
module op_decoder
    import zpu_isa_pkg::*;
    import zpu_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_valid_i,
    input  logic [7:0] inst_byte_i,
    output logic       dec_valid_o,
    output exec_op_e   dec_op_o,
    output imm_t       dec_imm_o
);

    // set while the last accepted byte was an im
    logic     idim;
    exec_op_e op_c;

    always_comb begin
        op_c = exe_nop;
        if (inst_byte_i[7]) begin
            op_c = idim ? exe_imn : exe_im0;
        end else begin
            case (inst_byte_i)
                op_add_c:       op_c = exe_add;
                op_and_c:       op_c = exe_and;
                op_or_c:        op_c = exe_or;
                op_not_c:       op_c = exe_not;
                op_flip_c:      op_c = exe_flip;
                op_nop_c:       op_c = exe_nop;
                op_lessthan_c:  op_c = exe_lessthan;
                op_ulessthan_c: op_c = exe_ulessthan;
                op_mult_c:      op_c = exe_mul;
                op_eq_c:        op_c = exe_eq;
                op_sub_c:       op_c = exe_sub;
                // unknown bytes run as nop
                default:        op_c = exe_nop;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_o <= 1'b0;
            idim        <= 1'b0;
        end else begin
            dec_valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                idim <= inst_byte_i[7];
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            dec_op_o  <= op_c;
            dec_imm_o <= inst_byte_i[IMM_WIDTH-1:0];
        end
    end

endmodule

//--- hw/op_fifo.sv
module op_fifo
    import zpu_isa_pkg::*;
    import zpu_data_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_i,
    input  exec_op_e op_i,
    input  imm_t     imm_i,
    input  logic     pop_i,
    output logic     valid_o,
    output exec_op_e op_o,
    output imm_t     imm_o,
    output logic     credit_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    exec_op_e         op_mem  [FIFO_DEPTH];
    imm_t             imm_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign valid_o = (count != '0);
    assign op_o    = op_mem[rd_ptr];
    assign imm_o   = imm_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_i) begin
            op_mem[wr_ptr]  <= op_i;
            imm_mem[wr_ptr] <= imm_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            // every pop hands one slot back to the sender
            credit_o <= pop_i;
            if (wr_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a sender that keeps to its credits never overruns the buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_i |-> (count != CNT_W'(FIFO_DEPTH)));

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop_i |-> (count != '0));

endmodule

//--- hw/stack_exec.sv
module stack_exec
    import zpu_isa_pkg::*;
    import zpu_data_pkg::*;
#(
    parameter int STACK_DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_i,
    input  exec_op_e op_i,
    input  imm_t     imm_i,
    output logic     pop_o,
    output logic     res_valid_o,
    output word_t    tos_o,
    output word_t    nos_o
);

    localparam int W = $bits(word_t);

    typedef enum logic [1:0] {
        st_idle,
        st_mul1,
        st_mul2
    } exec_state_e;

    exec_state_e        state;
    word_t              stk [STACK_DEPTH];
    word_t              alu_res;
    word_t              flip_w;
    logic               do_push;
    logic               do_pull;
    logic signed [W-1:0] mul_p1;
    logic signed [W-1:0] mul_p2;

    assign tos_o = stk[0];
    assign nos_o = stk[1];

    // take a new op only when no multiply is running
    assign pop_o = valid_i && (state == st_idle);

    always_comb begin
        for (int i = 0; i < W; i++) begin
            flip_w[i] = stk[0][W-1-i];
        end
    end

    ////////////////////////////////////////////////////////////////////
    // result and stack movement per op
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_res = stk[0];
        do_push = 1'b0;
        do_pull = 1'b0;
        case (op_i)
            exe_im0: begin
                alu_res = {{(W-IMM_WIDTH){imm_i[IMM_WIDTH-1]}}, imm_i};
                do_push = 1'b1;
            end
            exe_imn:  alu_res = {stk[0][W-IMM_WIDTH-1:0], imm_i};
            exe_not:  alu_res = ~stk[0];
            exe_flip: alu_res = flip_w;
            exe_add: begin
                alu_res = stk[0] + stk[1];
                do_pull = 1'b1;
            end
            exe_and: begin
                alu_res = stk[0] & stk[1];
                do_pull = 1'b1;
            end
            exe_or: begin
                alu_res = stk[0] | stk[1];
                do_pull = 1'b1;
            end
            exe_sub: begin
                alu_res = stk[1] - stk[0];
                do_pull = 1'b1;
            end
            exe_eq: begin
                alu_res = W'(stk[0] == stk[1]);
                do_pull = 1'b1;
            end
            exe_lessthan: begin
                alu_res = W'($signed(stk[0]) < $signed(stk[1]));
                do_pull = 1'b1;
            end
            exe_ulessthan: begin
                alu_res = W'(stk[0] < stk[1]);
                do_pull = 1'b1;
            end
            // tos is rewritten later from the product
            exe_mul:  do_pull = 1'b1;
            default:  alu_res = stk[0];
        endcase
    end

    // two product stages, free running
    always_ff @(posedge clk) begin
        mul_p1 <= $signed(stk[0]) * $signed(stk[1]);
        mul_p2 <= mul_p1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            res_valid_o <= 1'b0;
            for (int i = 0; i < STACK_DEPTH; i++) begin
                stk[i] <= '0;
            end
        end else begin
            res_valid_o <= 1'b0;
            case (state)
                st_idle: begin
                    if (pop_o) begin
                        if (op_i == exe_mul) begin
                            state <= st_mul1;
                        end else begin
                            res_valid_o <= 1'b1;
                        end
                        stk[0] <= alu_res;
                        if (do_push) begin
                            // bottom entry falls off
                            for (int i = 1; i < STACK_DEPTH; i++) begin
                                stk[i] <= stk[i-1];
                            end
                        end else if (do_pull) begin
                            for (int i = 1; i < STACK_DEPTH - 1; i++) begin
                                stk[i] <= stk[i+1];
                            end
                            stk[STACK_DEPTH-1] <= '0;
                        end
                    end
                end
                st_mul1: state <= st_mul2;
                st_mul2: begin
                    stk[0]      <= mul_p2;
                    res_valid_o <= 1'b1;
                    state       <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // mul holds the FIFO off until its product lands three cycles on
    a_mul_seq: assert property (@(posedge clk) disable iff (rst)
        (pop_o && op_i == exe_mul) |=> !pop_o ##1 !pop_o ##1 res_valid_o);

endmodule

//--- hw/zpu_exec_top.sv
module zpu_exec_top
    import zpu_isa_pkg::*;
    import zpu_data_pkg::*;
#(
    parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH,
    parameter int STACK_DEPTH = DEF_STACK_DEPTH
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_valid_i,
    input  logic [7:0] inst_byte_i,
    output logic       credit_o,
    output logic       res_valid_o,
    output word_t      tos_o,
    output word_t      nos_o
);

    logic     dec_valid;
    exec_op_e dec_op;
    imm_t     dec_imm;
    logic     fifo_valid;
    exec_op_e fifo_op;
    imm_t     fifo_imm;
    logic     pop;

    op_decoder u_decoder (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_byte_i  (inst_byte_i),
        .dec_valid_o  (dec_valid),
        .dec_op_o     (dec_op),
        .dec_imm_o    (dec_imm)
    );

    // credits reserve the slot, so no ready back to the decoder
    op_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_i     (dec_valid),
        .op_i     (dec_op),
        .imm_i    (dec_imm),
        .pop_i    (pop),
        .valid_o  (fifo_valid),
        .op_o     (fifo_op),
        .imm_o    (fifo_imm),
        .credit_o (credit_o)
    );

    stack_exec #(
        .STACK_DEPTH (STACK_DEPTH)
    ) u_exec (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (fifo_valid),
        .op_i        (fifo_op),
        .imm_i       (fifo_imm),
        .pop_o       (pop),
        .res_valid_o (res_valid_o),
        .tos_o       (tos_o),
        .nos_o       (nos_o)
    );

endmodule

//--- verif/zpu_ref_model.svh
`ifndef ZPU_REF_MODEL_SVH
`define ZPU_REF_MODEL_SVH

// expected register stack, entry 0 is tos
word_t model_stk [STACK_DEPTH];
logic  model_idim;

function automatic void model_clear();
    for (int i = 0; i < STACK_DEPTH; i++) begin
        model_stk[i] = '0;
    end
    model_idim = 1'b0;
endfunction

// bottom entry is lost
function automatic void model_push(input word_t v);
    for (int i = STACK_DEPTH - 1; i > 0; i--) begin
        model_stk[i] = model_stk[i-1];
    end
    model_stk[0] = v;
endfunction

// zero comes in at the bottom
function automatic void model_pull();
    for (int i = 0; i < STACK_DEPTH - 1; i++) begin
        model_stk[i] = model_stk[i+1];
    end
    model_stk[STACK_DEPTH-1] = '0;
endfunction

function automatic word_t bit_reverse(input word_t v);
    word_t r;
    for (int i = 0; i < 32; i++) begin
        r[31-i] = v[i];
    end
    return r;
endfunction

function automatic void apply_byte(input logic [7:0] b, output word_t exp_tos,
                                   output word_t exp_nos);
    word_t  t;
    word_t  n;
    word_t  r;
    logic   pull;
    longint prod;
    t    = model_stk[0];
    n    = model_stk[1];
    r    = t;
    pull = 1'b0;
    if (b[7]) begin
        if (model_idim) begin
            model_stk[0] = (t << IMM_WIDTH) | word_t'(b[IMM_WIDTH-1:0]);
        end else begin
            model_push({{(32-IMM_WIDTH){b[IMM_WIDTH-1]}}, b[IMM_WIDTH-1:0]});
        end
    end else begin
        case (b)
            op_add_c:       r = t + n;
            op_and_c:       r = t & n;
            op_or_c:        r = t | n;
            op_sub_c:       r = n - t;
            op_eq_c:        r = (t == n) ? 32'd1 : 32'd0;
            op_lessthan_c:  r = ($signed(t) < $signed(n)) ? 32'd1 : 32'd0;
            op_ulessthan_c: r = (t < n) ? 32'd1 : 32'd0;
            op_mult_c: begin
                prod = longint'($signed(t)) * longint'($signed(n));
                r    = prod[31:0];
            end
            op_not_c:       r = ~t;
            op_flip_c:      r = bit_reverse(t);
            default:        r = t;
        endcase
        case (b)
            op_add_c, op_and_c, op_or_c, op_sub_c, op_eq_c,
            op_lessthan_c, op_ulessthan_c, op_mult_c: pull = 1'b1;
            default: pull = 1'b0;
        endcase
        if (pull) begin
            model_pull();
        end
        model_stk[0] = r;
    end
    model_idim = b[7];
    exp_tos    = model_stk[0];
    exp_nos    = model_stk[1];
endfunction

`endif

//--- verif/tb_zpu_exec.sv
module tb_zpu_exec
    import zpu_isa_pkg::*;
    import zpu_data_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH  = DEF_FIFO_DEPTH;
    localparam int STACK_DEPTH = DEF_STACK_DEPTH;
    localparam int WAIT_LIMIT  = 500;

    logic       clk;
    logic       rst;
    logic       inst_valid;
    logic [7:0] inst_byte;
    logic       credit;
    logic       res_valid;
    word_t      tos;
    word_t      nos;

    integer     seed;
    logic       burst_mode;
    int         sent_cnt = 0;
    int         back_cnt = 0;
    word_t      exp_tos_q [$];
    word_t      exp_nos_q [$];
    logic [7:0] bin_ops [4] = '{op_add_c, op_and_c, op_or_c, op_sub_c};
    logic [7:0] cmp_ops [3] = '{op_lessthan_c, op_ulessthan_c, op_eq_c};
    logic [7:0] odd_ops [3] = '{8'h00, 8'h3C, 8'h7F};

    `include "zpu_ref_model.svh"

    zpu_exec_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .STACK_DEPTH (STACK_DEPTH)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid),
        .inst_byte_i  (inst_byte),
        .credit_o     (credit),
        .res_valid_o  (res_valid),
        .tos_o        (tos),
        .nos_o        (nos)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %08h, expected %08h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    // credit return counter
    always @(posedge clk) begin
        if (rst) begin
            back_cnt <= 0;
        end else if (credit) begin
            back_cnt <= back_cnt + 1;
        end
    end

    // one expected entry per result pulse
    always @(posedge clk) begin
        if (!rst && res_valid) begin
            if (exp_tos_q.size() == 0) begin
                $display("a result came out at %0t with no byte left to match it", $time);
                $display("SOME TESTS FAILED");
                $fatal(1, "extra result");
            end else begin
                compare_word("tos_o", tos, exp_tos_q.pop_front());
                compare_word("nos_o", nos, exp_nos_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int credits_free();
        return FIFO_DEPTH - sent_cnt + back_cnt;
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    task automatic wait_credit();
        int cycles;
        cycles = 0;
        while (credits_free() == 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout("a credit to come back");
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        word_t e_tos;
        word_t e_nos;
        int    gap;
        wait_credit();
        if (!burst_mode) begin
            gap = $random(seed) & 3;
            if (gap < 2) begin
                gap = 0;
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        apply_byte(b, e_tos, e_nos);
        exp_tos_q.push_back(e_tos);
        exp_nos_q.push_back(e_nos);
        inst_valid = 1'b1;
        inst_byte  = b;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        sent_cnt++;
    endtask

    // five im bytes cover 32 bits, the nop ends the chain
    task automatic push_const(input word_t v);
        logic [34:0] ext;
        ext = {{3{v[31]}}, v};
        send_byte({1'b1, ext[34:28]});
        send_byte({1'b1, ext[27:21]});
        send_byte({1'b1, ext[20:14]});
        send_byte({1'b1, ext[13:7]});
        send_byte({1'b1, ext[6:0]});
        send_byte(op_nop_c);
    endtask

    task automatic run_pair(input word_t a, input word_t b, input logic [7:0] op);
        push_const(b);
        push_const(a);
        send_byte(op);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_tos_q.size() != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout("the pending results to drain");
            end
        end
    endtask

    task automatic check_credits();
        compare_count("free credits", credits_free(), FIFO_DEPTH);
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        compare_count("credit_o pulses", back_cnt, sent_cnt);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        word_t a;
        seed       = 32'h9886e9d3;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_byte  = '0;
        burst_mode = 1'b0;
        model_clear();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // immediates, single and chained
        send_byte(8'h85);
        send_byte(op_nop_c);
        send_byte(8'hFF);
        send_byte(8'h81);
        send_byte(8'h80);
        send_byte(op_nop_c);
        send_byte(8'hC0);
        send_byte(8'h80);
        send_byte(op_nop_c);
        push_const(32'hDEADBEEF);
        push_const(32'h80000000);
        push_const(32'hFFFFFF80);

        // arithmetic and logic
        for (int i = 0; i < 8; i++) begin
            push_const(rand_word());
            push_const(rand_word());
            send_byte(bin_ops[i % 4]);
            send_byte(op_not_c);
            send_byte(op_flip_c);
        end

        // comparisons, signed and unsigned disagree on the first two
        for (int i = 0; i < 3; i++) begin
            run_pair(32'h00000001, 32'hFFFFFFFF, cmp_ops[i]);
            run_pair(32'hFFFFFFFF, 32'h00000001, cmp_ops[i]);
            run_pair(32'h00000005, 32'h00000005, cmp_ops[i]);
            a = rand_word();
            run_pair(a, a, cmp_ops[i]);
            run_pair(rand_word(), rand_word(), cmp_ops[i]);
        end

        // multiply mixed with single-cycle ops
        for (int i = 0; i < 6; i++) begin
            push_const(rand_word());
            push_const((i % 2) ? -32'sd7 : rand_word());
            send_byte(op_mult_c);
            send_byte(8'hFD);
            send_byte(op_mult_c);
            send_byte(op_add_c);
            send_byte(op_flip_c);
        end

        // burst against the credit limit
        wait_drain();
        check_credits();
        burst_mode = 1'b1;
        for (int i = 0; i < 3 * FIFO_DEPTH; i++) begin
            send_byte({1'b1, 7'(i + 1)});
            send_byte((i % 2) ? op_mult_c : op_add_c);
        end
        burst_mode = 1'b0;
        wait_drain();
        check_credits();

        // overfill the stack, then pull it empty
        for (int i = 0; i < STACK_DEPTH + 3; i++) begin
            send_byte({1'b1, 7'(i + 1)});
            send_byte(odd_ops[i % 3]);
        end
        for (int i = 0; i < STACK_DEPTH + 2; i++) begin
            send_byte(op_or_c);
        end

        wait_drain();
        check_credits();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+verif
hw/zpu_isa_pkg.sv
hw/zpu_data_pkg.sv
hw/op_decoder.sv
hw/op_fifo.sv
hw/stack_exec.sv
hw/zpu_exec_top.sv
verif/tb_zpu_exec.sv

//--- Bender.yml
package:
  name: zpu_exec

sources:
  - files:
      - hw/zpu_isa_pkg.sv
      - hw/zpu_data_pkg.sv
      - hw/op_decoder.sv
      - hw/op_fifo.sv
      - hw/stack_exec.sv
      - hw/zpu_exec_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_zpu_exec.sv
